// File: hw/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // number of wakeup lanes: two alu results plus one external
    localparam int NUM_WKUP = 3;

    typedef logic [5:0]  rob_id_t;
    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // one source operand, data valid once rdy is set
    typedef struct packed {
        logic    rdy;
        rob_id_t tag;
        word_t   data;
    } src_t;

    typedef struct packed {
        alu_op_t op;
        rob_id_t dest;
        src_t    src1;
        src_t    src2;
        logic    use_imm;
        word_t   imm;
    } disp_pkt_t;

    typedef struct packed {
        alu_op_t op;
        rob_id_t dest;
        word_t   opa;
        word_t   opb;
    } issue_pkt_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } wkup_t;

    function automatic word_t alu_compute(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD: alu_compute = a + b;
            ALU_SUB: alu_compute = a - b;
            ALU_AND: alu_compute = a & b;
            ALU_OR:  alu_compute = a | b;
            ALU_XOR: alu_compute = a ^ b;
            // shift amount from the low five bits only
            ALU_SLL: alu_compute = a << b[4:0];
            ALU_SRL: alu_compute = a >> b[4:0];
            ALU_SLT: alu_compute = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: alu_compute = '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/iq_entry.sv
`default_nettype none

module iq_entry #(
    parameter int AGING_LENGTH = 4
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n_i,
    input  wire logic                    flush_i,
    input  wire logic                    alloc_i,
    input  iq_pkg::disp_pkt_t            pkt_i,
    input  iq_pkg::wkup_t                wkup_i [iq_pkg::NUM_WKUP],
    input  wire logic                    issue_i,
    output logic                         valid_o,
    output logic                         ready_o,
    output logic [AGING_LENGTH-1:0]      age_o,
    output iq_pkg::issue_pkt_t           issue_o
);

    logic                    valid_q;
    logic [AGING_LENGTH-1:0] age_q;
    iq_pkg::disp_pkt_t       pkt_q;
    iq_pkg::src_t            src1_nxt;
    iq_pkg::src_t            src2_nxt;

    // capture data for a waiting source on a tag match
    function automatic iq_pkg::src_t snoop(iq_pkg::src_t s, iq_pkg::wkup_t w);
        snoop = s;
        if (!s.rdy && w.valid && (w.tag == s.tag)) begin
            snoop.rdy  = 1'b1;
            snoop.data = w.data;
        end
    endfunction

    ////////////////////
    // operand wakeup
    // incoming packet is snooped too, so a same-cycle broadcast is not lost
    always_comb begin
        src1_nxt = alloc_i ? pkt_i.src1 : pkt_q.src1;
        src2_nxt = alloc_i ? pkt_i.src2 : pkt_q.src2;
        for (int k = 0; k < iq_pkg::NUM_WKUP; k++) begin
            src1_nxt = snoop(src1_nxt, wkup_i[k]);
            src2_nxt = snoop(src2_nxt, wkup_i[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            pkt_q <= pkt_i;
        end
        pkt_q.src1 <= src1_nxt;
        pkt_q.src2 <= src2_nxt;
    end

    ////////////////////
    // occupancy and aging
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            age_q   <= '0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            age_q   <= '0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
            age_q   <= '0;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end else if (valid_q && (age_q != '1)) begin
            // saturate at max age
            age_q <= age_q + 1'b1;
        end
    end

    assign valid_o = valid_q;
    assign age_o   = age_q;
    assign ready_o = valid_q && pkt_q.src1.rdy && pkt_q.src2.rdy;

    assign issue_o.op   = pkt_q.op;
    assign issue_o.dest = pkt_q.dest;
    assign issue_o.opa  = pkt_q.src1.data;
    assign issue_o.opb  = pkt_q.use_imm ? pkt_q.imm : pkt_q.src2.data;

endmodule

`default_nettype wire

// File: hw/age_select.sv
`default_nettype none

module age_select #(
    parameter int BANK_SIZE    = 4,
    parameter int AGING_LENGTH = 4
) (
    input  wire logic [BANK_SIZE-1:0]                   ready_i,
    input  wire logic [BANK_SIZE-1:0][AGING_LENGTH-1:0] age_i,
    output logic                                        grant_valid_o,
    output logic [$clog2(BANK_SIZE)-1:0]                grant_idx_o
);

    localparam int IDX_W  = $clog2(BANK_SIZE);
    // tree is padded up to a power of two
    localparam int LEAVES = 1 << IDX_W;

    // heap layout, node n has children 2n and 2n+1, root is node 1
    logic                    node_vld [1:2*LEAVES-1];
    logic [AGING_LENGTH-1:0] node_age [1:2*LEAVES-1];
    logic [IDX_W-1:0]        node_idx [1:2*LEAVES-1];

    always_comb begin
        // leaves, padding slots never request
        for (int i = 0; i < LEAVES; i++) begin
            node_vld[LEAVES+i] = 1'b0;
            node_age[LEAVES+i] = '0;
            node_idx[LEAVES+i] = IDX_W'(i);
            if (i < BANK_SIZE) begin
                node_vld[LEAVES+i] = ready_i[i];
                node_age[LEAVES+i] = age_i[i];
            end
        end

        // left child always covers the lower indices,
        // so right only wins when strictly older
        for (int n = LEAVES - 1; n >= 1; n--) begin
            if (node_vld[2*n+1] &&
                (!node_vld[2*n] || (node_age[2*n+1] > node_age[2*n]))) begin
                node_vld[n] = 1'b1;
                node_age[n] = node_age[2*n+1];
                node_idx[n] = node_idx[2*n+1];
            end else begin
                node_vld[n] = node_vld[2*n];
                node_age[n] = node_age[2*n];
                node_idx[n] = node_idx[2*n];
            end
        end
    end

    assign grant_valid_o = node_vld[1];
    assign grant_idx_o   = node_idx[1];

endmodule

`default_nettype wire

// File: hw/alu_iq.sv
`default_nettype none

module alu_iq #(
    parameter int BANK_SIZE    = 4,
    parameter int AGING_LENGTH = 4
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n_i,
    input  wire logic                      flush_i,
    input  wire logic [1:0]                disp_valid_i,
    input  iq_pkg::disp_pkt_t [1:0]        disp_pkt_i,
    output logic [1:0]                     iq_ready_o,
    input  iq_pkg::wkup_t                  wkup_i [iq_pkg::NUM_WKUP],
    output logic [1:0]                     issue_valid_o,
    output iq_pkg::issue_pkt_t [1:0]       issue_o
);

    localparam int IDX_W = $clog2(BANK_SIZE);
    localparam int CNT_W = $clog2(BANK_SIZE + 1);

    logic [1:0][BANK_SIZE-1:0]                   ent_valid;
    logic [1:0][BANK_SIZE-1:0]                   ent_ready;
    logic [1:0][BANK_SIZE-1:0][AGING_LENGTH-1:0] ent_age;
    iq_pkg::issue_pkt_t [1:0][BANK_SIZE-1:0]     ent_pkt;
    logic [1:0][BANK_SIZE-1:0]                   ent_alloc;
    logic [1:0][BANK_SIZE-1:0]                   ent_issue;

    logic [1:0][BANK_SIZE-1:0] free_vec;
    logic [1:0]                disp_fire;
    logic [1:0][CNT_W-1:0]     free_cnt_q;
    logic [1:0][IDX_W-1:0]     grant_idx;

    for (genvar b = 0; b < 2; b++) begin : g_bank

        ////////////////////
        // allocation
        // lowest free slot, isolated by x & -x
        assign free_vec[b]  = ~ent_valid[b];
        assign disp_fire[b] = disp_valid_i[b] && iq_ready_o[b];
        assign ent_alloc[b] = disp_fire[b] ? (free_vec[b] & (~free_vec[b] + 1'b1)) : '0;

        // free count, one in per dispatch and one back per issue
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                free_cnt_q[b] <= CNT_W'(BANK_SIZE);
            end else if (flush_i) begin
                free_cnt_q[b] <= CNT_W'(BANK_SIZE);
            end else begin
                free_cnt_q[b] <= free_cnt_q[b] - CNT_W'(disp_fire[b])
                                 + CNT_W'(issue_valid_o[b]);
            end
        end

        assign iq_ready_o[b] = (free_cnt_q[b] != '0);

        ////////////////////
        // entries of this bank
        for (genvar j = 0; j < BANK_SIZE; j++) begin : g_ent
            iq_entry #(
                .AGING_LENGTH (AGING_LENGTH)
            ) u_entry (
                .clk      (clk),
                .arst_n_i (arst_n_i),
                .flush_i  (flush_i),
                .alloc_i  (ent_alloc[b][j]),
                .pkt_i    (disp_pkt_i[b]),
                .wkup_i   (wkup_i),
                .issue_i  (ent_issue[b][j]),
                .valid_o  (ent_valid[b][j]),
                .ready_o  (ent_ready[b][j]),
                .age_o    (ent_age[b][j]),
                .issue_o  (ent_pkt[b][j])
            );

            assign ent_issue[b][j] = issue_valid_o[b] && (grant_idx[b] == IDX_W'(j));
        end

        ////////////////////
        // select and issue
        age_select #(
            .BANK_SIZE    (BANK_SIZE),
            .AGING_LENGTH (AGING_LENGTH)
        ) u_select (
            .ready_i       (ent_ready[b]),
            .age_i         (ent_age[b]),
            .grant_valid_o (issue_valid_o[b]),
            .grant_idx_o   (grant_idx[b])
        );

        assign issue_o[b] = ent_pkt[b][grant_idx[b]];
    end

endmodule

`default_nettype wire

// File: hw/alu_exec.sv
`default_nettype none

module alu_exec (
    input  wire logic          clk,
    input  wire logic          arst_n_i,
    input  wire logic          flush_i,
    input  wire logic          issue_valid_i,
    input  iq_pkg::issue_pkt_t issue_i,
    output iq_pkg::wkup_t      wkup_o
);

    iq_pkg::word_t   result;
    logic            valid_q;
    iq_pkg::rob_id_t tag_q;
    iq_pkg::word_t   data_q;

    // single cycle, result registered straight onto the wakeup lane
    assign result = iq_pkg::alu_compute(issue_i.op, issue_i.opa, issue_i.opb);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i;
        end
    end

    // payload only loads on a real issue
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            tag_q  <= issue_i.dest;
            data_q <= result;
        end
    end

    assign wkup_o.valid = valid_q;
    assign wkup_o.tag   = tag_q;
    assign wkup_o.data  = data_q;

endmodule

`default_nettype wire

// File: hw/alu_issue_top.sv
`default_nettype none

module alu_issue_top #(
    parameter int BANK_SIZE    = 4,
    parameter int AGING_LENGTH = 4
) (
    input  wire logic                clk,
    input  wire logic                arst_n_i,
    input  wire logic                flush_i,
    input  wire logic [1:0]          disp_valid_i,
    input  iq_pkg::disp_pkt_t [1:0]  disp_pkt_i,
    output logic [1:0]               iq_ready_o,
    input  iq_pkg::wkup_t            ext_wkup_i,
    output iq_pkg::wkup_t [1:0]      res_o
);

    iq_pkg::wkup_t            wkup [iq_pkg::NUM_WKUP];
    logic [1:0]               issue_valid;
    iq_pkg::issue_pkt_t [1:0] issue;

    // lanes 0 and 1 are the alu results, lane 2 external
    assign wkup[0] = res_o[0];
    assign wkup[1] = res_o[1];
    assign wkup[2] = ext_wkup_i;

    alu_iq #(
        .BANK_SIZE    (BANK_SIZE),
        .AGING_LENGTH (AGING_LENGTH)
    ) u_iq (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .disp_valid_i  (disp_valid_i),
        .disp_pkt_i    (disp_pkt_i),
        .iq_ready_o    (iq_ready_o),
        .wkup_i        (wkup),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    for (genvar i = 0; i < 2; i++) begin : g_alu
        alu_exec u_alu (
            .clk           (clk),
            .arst_n_i      (arst_n_i),
            .flush_i       (flush_i),
            .issue_valid_i (issue_valid[i]),
            .issue_i       (issue[i]),
            .wkup_o        (res_o[i])
        );
    end

endmodule

`default_nettype wire

// File: tb/alu_issue_props.sv
`default_nettype none

module alu_issue_props #(
    parameter int BANK_SIZE = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,
    input  wire logic                                 flush_i,
    input  wire logic [1:0]                           disp_valid_i,
    input  wire logic [1:0]                           iq_ready_i,
    input  wire logic [1:0]                           issue_valid_i,
    input  wire logic [1:0][BANK_SIZE-1:0]            ent_valid_i,
    input  wire logic [1:0][BANK_SIZE-1:0]            ent_ready_i,
    input  wire logic [1:0][$clog2(BANK_SIZE)-1:0]    grant_idx_i
);
    timeunit 1ns;
    timeprecision 100ps;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        // upstream has to hold while the bank is full
        a_no_disp_full: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            disp_valid_i[b] |-> iq_ready_i[b]
        ) else $error("dispatch on bank %0d while it has no free entry", b);

        a_issue_ready: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            issue_valid_i[b] |-> (ent_valid_i[b][grant_idx_i[b]] && ent_ready_i[b][grant_idx_i[b]])
        ) else $error("bank %0d issued an entry that is empty or still waiting", b);

        // entries are gone one cycle after flush
        a_flush_idle: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            flush_i |=> !issue_valid_i[b]
        ) else $error("bank %0d issued in the cycle after a flush", b);
    end

endmodule

bind alu_iq alu_issue_props #(
    .BANK_SIZE (BANK_SIZE)
) u_props (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .disp_valid_i  (disp_valid_i),
    .iq_ready_i    (iq_ready_o),
    .issue_valid_i (issue_valid_o),
    .ent_valid_i   (ent_valid),
    .ent_ready_i   (ent_ready),
    .grant_idx_i   (grant_idx)
);

`default_nettype wire

// File: tb/alu_issue_tb.sv
`default_nettype none

module alu_issue_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BANK_SIZE    = 4;
    localparam int AGING_LENGTH = 4;
    localparam int N_RAND       = 200;
    // instructions of the fixed scenarios
    localparam int N_DIRECTED   = 14;
    localparam int CYCLE_LIMIT  = 40 * (N_RAND + N_DIRECTED) + 200;
    localparam int MAX_SEQ      = 256;
    // rob ids from here up stand for results of other units
    localparam int EXT_BASE     = 48;
    localparam int N_EXT        = 16;

    logic                     clk;
    logic                     arst_n;
    logic                     flush;
    logic [1:0]               disp_valid;
    iq_pkg::disp_pkt_t [1:0]  disp_pkt;
    logic [1:0]               iq_ready;
    iq_pkg::wkup_t            ext_wkup;
    iq_pkg::wkup_t [1:0]      res;

    integer seed = 32'h3e7c4f5a;
    string  test_name;
    int     cycles;
    int     outstanding;
    int     seq_cnt;
    int     tag_ptr;
    int     occ [2];

    // model state, one slot per dispatched instruction
    iq_pkg::rob_id_t seq_tag  [MAX_SEQ];
    int              seq_bank [MAX_SEQ];
    iq_pkg::word_t   exp_val  [MAX_SEQ];
    int              dep1     [MAX_SEQ];
    int              dep2     [MAX_SEQ];
    bit              live     [MAX_SEQ];
    bit              done     [MAX_SEQ];
    int              done_cyc [MAX_SEQ];
    bit              tag_busy [64];
    int              tag_seq  [64];
    bit              ext_pending [N_EXT];
    iq_pkg::word_t   ext_data    [N_EXT];
    iq_pkg::rob_id_t order_q [$];

    alu_issue_top #(
        .BANK_SIZE    (BANK_SIZE),
        .AGING_LENGTH (AGING_LENGTH)
    ) dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .flush_i      (flush),
        .disp_valid_i (disp_valid),
        .disp_pkt_i   (disp_pkt),
        .iq_ready_o   (iq_ready),
        .ext_wkup_i   (ext_wkup),
        .res_o        (res)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rnd(int n);
        rnd = int'($unsigned($random(seed)) % n);
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    ////////////////////
    // compare tasks
    task automatic check_result(string name, iq_pkg::word_t exp, iq_pkg::word_t act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_tag(string name, iq_pkg::rob_id_t exp, iq_pkg::rob_id_t act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_now($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    ////////////////////
    // reference model
    // a producer may feed a consumer until the cycle its result is on the bus
    function automatic bit can_feed(int p);
        can_feed = live[p] && (!done[p] || (done_cyc[p] == cycles));
    endfunction

    function automatic bit fed_before(int p);
        fed_before = (p < 0) || (done[p] && (done_cyc[p] < cycles));
    endfunction

    task automatic build_src(int kind, int idx, output iq_pkg::src_t s, output iq_pkg::word_t v);
        s = '0;
        case (kind)
            1: begin
                s.tag = seq_tag[idx];
                v     = exp_val[idx];
            end
            2: begin
                if (!ext_pending[idx]) begin
                    ext_pending[idx] = 1'b1;
                    ext_data[idx]    = $random(seed);
                end
                s.tag = iq_pkg::rob_id_t'(EXT_BASE + idx);
                v     = ext_data[idx];
            end
            default: begin
                s.rdy  = 1'b1;
                s.data = $random(seed);
                v      = s.data;
            end
        endcase
    endtask

    task automatic dispatch(int lane, int k1, int i1, int k2, int i2, output int s);
        iq_pkg::disp_pkt_t pkt;
        iq_pkg::src_t      a;
        iq_pkg::src_t      b;
        iq_pkg::word_t     v1;
        iq_pkg::word_t     v2;
        int                t;
        t = -1;
        for (int n = 0; n < EXT_BASE && t < 0; n++) begin
            if (!tag_busy[(tag_ptr + n) % EXT_BASE]) begin
                t = (tag_ptr + n) % EXT_BASE;
            end
        end
        if (t < 0 || seq_cnt >= MAX_SEQ) begin
            fail_now("testbench ran out of ROB ids or model slots");
        end
        s = seq_cnt;
        seq_cnt++;
        build_src(k1, i1, a, v1);
        build_src(k2, i2, b, v2);
        pkt.op      = iq_pkg::alu_op_t'(3'(rnd(8)));
        pkt.dest    = iq_pkg::rob_id_t'(t);
        pkt.src1    = a;
        pkt.src2    = b;
        pkt.use_imm = (k2 == 0) && (rnd(4) == 0);
        pkt.imm     = $random(seed);
        if (pkt.use_imm) begin
            v2 = pkt.imm;
        end
        exp_val[s]  = iq_pkg::alu_compute(pkt.op, v1, v2);
        seq_tag[s]  = pkt.dest;
        seq_bank[s] = lane;
        dep1[s]     = (k1 == 1) ? i1 : -1;
        dep2[s]     = (k2 == 1) ? i2 : -1;
        live[s]     = 1'b1;
        done[s]     = 1'b0;
        tag_busy[t] = 1'b1;
        tag_seq[t]  = s;
        tag_ptr     = (t + 1) % EXT_BASE;
        occ[lane]++;
        outstanding++;
        disp_valid[lane] = 1'b1;
        disp_pkt[lane]   = pkt;
    endtask

    task automatic pick_src(output int kind, output int idx);
        kind = rnd(3);
        idx  = 0;
        if (kind == 1) begin
            idx = seq_cnt - 1 - rnd(6);
            if (idx < 0 || !can_feed(idx)) begin
                kind = 0;
            end
        end else if (kind == 2) begin
            idx = rnd(N_EXT);
        end
    endtask

    task automatic broadcast(int e);
        ext_wkup.valid = 1'b1;
        ext_wkup.tag   = iq_pkg::rob_id_t'(EXT_BASE + e);
        ext_wkup.data  = ext_data[e];
        ext_pending[e] = 1'b0;
    endtask

    task automatic flush_all();
        flush = 1'b1;
        for (int s = 0; s < seq_cnt; s++) begin
            live[s] = 1'b0;
        end
        for (int t = 0; t < 64; t++) begin
            tag_busy[t] = 1'b0;
        end
        for (int e = 0; e < N_EXT; e++) begin
            ext_pending[e] = 1'b0;
        end
        occ[0]      = 0;
        occ[1]      = 0;
        outstanding = 0;
    endtask

    task automatic take_results();
        int s_now [2];
        for (int l = 0; l < 2; l++) begin
            s_now[l] = -1;
            if (res[l].valid) begin
                if (!tag_busy[res[l].tag]) begin
                    fail_now($sformatf("%s: result for tag %0d, which is not outstanding",
                                       test_name, res[l].tag));
                end
                s_now[l] = tag_seq[res[l].tag];
                if (seq_bank[s_now[l]] != l) begin
                    fail_now($sformatf("%s: tag %0d came out of the wrong ALU",
                                       test_name, res[l].tag));
                end
                check_result($sformatf("%s tag %0d", test_name, res[l].tag),
                             exp_val[s_now[l]], res[l].data);
                if (!fed_before(dep1[s_now[l]]) || !fed_before(dep2[s_now[l]])) begin
                    fail_now($sformatf("%s: tag %0d finished before its producer",
                                       test_name, res[l].tag));
                end
            end
        end
        for (int l = 0; l < 2; l++) begin
            if (s_now[l] >= 0) begin
                done[s_now[l]]     = 1'b1;
                done_cyc[s_now[l]] = cycles;
                tag_busy[res[l].tag] = 1'b0;
                occ[l]--;
                outstanding--;
                order_q.push_back(res[l].tag);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            fail_now($sformatf("timeout in %s with %0d instructions still outstanding",
                               test_name, outstanding));
        end
        disp_valid = '0;
        ext_wkup   = '0;
        flush      = 1'b0;
        take_results();
        for (int b = 0; b < 2; b++) begin
            check_ready($sformatf("%s ready bank %0d", test_name, b),
                        occ[b] < BANK_SIZE, iq_ready[b]);
        end
    endtask

    task automatic drain();
        while (outstanding > 0) begin
            for (int e = 0; e < N_EXT; e++) begin
                if (ext_pending[e] && !ext_wkup.valid) begin
                    broadcast(e);
                end
            end
            next_cycle();
        end
    endtask

    ////////////////////
    // test sequence
    initial begin
        int p;
        int c;
        int e;
        int n;
        int first;
        int k1;
        int k2;
        int i1;
        int i2;
        arst_n      = 1'b0;
        flush       = 1'b0;
        disp_valid  = '0;
        disp_pkt    = '0;
        ext_wkup    = '0;
        cycles      = 0;
        outstanding = 0;
        seq_cnt     = 0;
        tag_ptr     = 0;
        occ[0]      = 0;
        occ[1]      = 0;
        test_name   = "reset";
        repeat (16) @(posedge clk);
        #10;
        arst_n = 1'b1;
        check_ready("reset ready bank 0", 1'b1, iq_ready[0]);
        check_ready("reset ready bank 1", 1'b1, iq_ready[1]);

        // consumer dispatched while its producer result is on the bus
        test_name = "same cycle wakeup";
        dispatch(0, 0, 0, 0, 0, p);
        next_cycle();
        next_cycle();
        if (!done[p] || (done_cyc[p] != cycles)) begin
            fail_now("producer result did not appear two cycles after its dispatch");
        end
        dispatch(1, 1, p, 0, 0, c);
        drain();

        test_name = "bank full";
        e     = 0;
        first = seq_cnt;
        for (int m = 0; m < BANK_SIZE; m++) begin
            dispatch(0, 2, e, rnd(2) * 2, e, c);
            next_cycle();
        end
        check_ready(test_name, 1'b0, iq_ready[0]);
        // long enough for every age to saturate, leaving the index to break ties
        repeat (20) next_cycle();
        order_q.delete();
        broadcast(e);
        drain();
        if (order_q.size() != BANK_SIZE) begin
            fail_now("bank full: not every waiting instruction produced a result");
        end
        for (int m = 0; m < BANK_SIZE; m++) begin
            check_tag(test_name, seq_tag[first + m], order_q[m]);
        end

        // the freed slot 0 gets reused, so index order differs from age order
        test_name = "oldest first";
        e = 1;
        dispatch(1, 0, 0, 0, 0, p);
        next_cycle();
        first = seq_cnt;
        dispatch(1, 2, e, 0, 0, c);
        next_cycle();
        dispatch(1, 2, e, 0, 0, c);
        next_cycle();
        dispatch(1, 2, e, 0, 0, c);
        repeat (3) next_cycle();
        order_q.delete();
        broadcast(e);
        drain();
        if (order_q.size() != 3) begin
            fail_now("oldest first: wrong number of results after the wakeup");
        end
        for (int m = 0; m < 3; m++) begin
            check_tag(test_name, seq_tag[first + m], order_q[m]);
        end

        test_name = "random";
        n = 0;
        while (n < N_RAND) begin
            for (int l = 0; l < 2; l++) begin
                if (n < N_RAND && occ[l] < BANK_SIZE && rnd(4) != 0) begin
                    pick_src(k1, i1);
                    pick_src(k2, i2);
                    dispatch(l, k1, i1, k2, i2, c);
                    n++;
                end
            end
            if (rnd(2) == 0) begin
                e = rnd(N_EXT);
                for (int m = 0; m < N_EXT && !ext_wkup.valid; m++) begin
                    if (ext_pending[(e + m) % N_EXT]) begin
                        broadcast((e + m) % N_EXT);
                    end
                end
            end
            next_cycle();
        end
        drain();

        // waiting entries plus two in the ALUs when flush hits
        test_name = "flush";
        e = 2;
        dispatch(0, 2, e, 0, 0, c);
        dispatch(1, 2, e, 2, e, c);
        next_cycle();
        dispatch(0, 0, 0, 0, 0, c);
        dispatch(1, 0, 0, 0, 0, c);
        next_cycle();
        flush_all();
        next_cycle();
        broadcast(e);
        repeat (8) next_cycle();
        check_ready(test_name, 1'b1, iq_ready[0]);
        check_ready(test_name, 1'b1, iq_ready[1]);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/iq_pkg.sv
hw/iq_entry.sv
hw/age_select.sv
hw/alu_iq.sv
hw/alu_exec.sv
hw/alu_issue_top.sv
tb/alu_issue_props.sv
tb/alu_issue_tb.sv

// File: run.sh
#!/bin/sh
# build the issue stage testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module alu_issue_tb -f compile.f -o alu_issue_sim \
    && ./obj_dir/alu_issue_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
